//--- Bender.yml
package:
  name: oramSeed

sources:
  # Packages first, then the link interface
  - oramGeometryPkg.sv
  - seedTypesPkg.sv
  - seedLaneIf.sv
  # Design blocks, top level last
  - bucketIdGen.sv
  - gentrySeedGen.sv
  - padLane.sv
  - padCollector.sv
  - oramPadTop.sv
  # Self-checking testbench, top module tbOramPad
  - target: test
    files:
      - tbOramPad.sv

//--- bucketIdGen.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Bucket index walker
// Steps heap indices root to leaf, child picked by successive leaf bits
// ----------------------------------------------------------------------
module bucketIdGen (
	input  logic                   Clock,
	input  logic                   reset,
	input  logic                   reStart,
	input  seedTypesPkg::leafT     leaf,
	input  logic                   advance,
	output seedTypesPkg::bucketIdT bucketId
);
	import oramGeometryPkg::*;
	import seedTypesPkg::*;

	// Remaining leaf bits, lowest is the next choice
	leafT leafShift;
	// Current depth, root is level 0
	logic [LevelWidth-1:0] level;
	bucketIdT bucketIdReg;
	logic atLeaf;
	bucketIdT childId;

	assign atLeaf = level == LevelWidth'(OramLevels);

	// Left child 2n+1, right child 2n+2
	assign childId = (bucketIdReg << 1) + BucketIdWidth'(1) + BucketIdWidth'(leafShift[0]);

	assign bucketId = bucketIdReg;

	// ------------------------------------------------------------------
	// Index and depth
	// ------------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (reset) begin
			bucketIdReg <= '0;
			level <= '0;
		end else if (reStart) begin
			bucketIdReg <= '0;
			level <= '0;
		end else if (advance && !atLeaf) begin
			bucketIdReg <= childId;
			level <= level + 1'b1;
		end
	end

	// Leaf bits consumed one per step
	always_ff @(posedge Clock) begin
		if (reStart) begin
			leafShift <= leaf;
		end else if (advance && !atLeaf) begin
			leafShift <= leafShift >> 1;
		end
	end

	// Generator must stop stepping once the leaf bucket is out
	aNoStepPastLeaf : assert property (@(posedge Clock) disable iff (reset)
		advance && !reStart |-> !atLeaf);

endmodule

//--- gentrySeedGen.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Gentry seed generator
// Read then write pass per path, seeds dealt round-robin to pad lanes
// ----------------------------------------------------------------------
module gentrySeedGen (
	input logic       Clock,
	input logic       reset,
	seedLaneIf.source lanes [oramGeometryPkg::LaneCount-1:0]
);
	import oramGeometryPkg::*;
	import seedTypesPkg::*;

	rwPhaseT state;
	rwPhaseT nextState;
	logic startOp;
	logic writePhase;
	logic itemValid;
	logic curReady;
	logic transfer;
	logic lastTransfer;
	// Items sent in the current pass
	logic [LevelWidth-1:0] xferCount;
	seedT pathCounter;
	// Counter >> level, shifted once per item
	seedT seedShift;
	seedT itemSeed;
	bucketIdT itemBucketId;
	leafT pathLeaf;
	laneIdxT lanePtr;
	logic [LaneCount-1:0] laneReady;

	// ------------------------------------------------------------------
	// Phase decode and handshake
	// ------------------------------------------------------------------
	assign startOp = (state == StartRead) || (state == StartWrite);
	assign writePhase = state == Write;

	// Nothing offered during the load cycle
	assign itemValid = !startOp;
	assign curReady = laneReady[lanePtr];
	assign transfer = itemValid && curReady;
	assign lastTransfer = transfer && (xferCount == LevelWidth'(PathBuckets - 1));

	always_comb begin
		nextState = state;
		case (state)
			StartRead: nextState = Read;
			Read: begin
				if (lastTransfer)
					nextState = StartWrite;
			end
			StartWrite: nextState = Write;
			Write: begin
				if (lastTransfer)
					nextState = StartRead;
			end
			default: nextState = StartRead;
		endcase
	end

	// ------------------------------------------------------------------
	// Control registers
	// ------------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (reset) begin
			state <= StartRead;
			xferCount <= '0;
			pathCounter <= '0;
			lanePtr <= '0;
		end else begin
			state <= nextState;
			if (lastTransfer)
				xferCount <= '0;
			else if (transfer)
				xferCount <= xferCount + 1'b1;
			// Next path once the write pass is done
			if (lastTransfer && writePhase)
				pathCounter <= pathCounter + SeedWidth'(1);
			if (transfer)
				lanePtr <= laneIdxT'(lanePtr + 1'b1);
		end
	end

	// Level k seed is counter >> k, one shift per item
	always_ff @(posedge Clock) begin
		if (startOp)
			seedShift <= pathCounter;
		else if (transfer)
			seedShift <= seedShift >> 1;
	end

	// Write pass re-encrypts with seed plus one
	assign itemSeed = writePhase ? seedShift + SeedWidth'(1) : seedShift;

	// Leaf is the low counter bits
	assign pathLeaf = pathCounter[OramLevels-1:0];

	// Last item of a pass leaves the walker at the leaf
	bucketIdGen bucketWalk (
		.Clock(Clock),
		.reset(reset),
		.reStart(startOp),
		.leaf(pathLeaf),
		.advance(transfer && !lastTransfer),
		.bucketId(itemBucketId)
	);

	// ------------------------------------------------------------------
	// Round-robin dispatch
	// ------------------------------------------------------------------
	for (genvar i = 0; i < LaneCount; i++) begin : gLane
		assign lanes[i].valid = itemValid && (lanePtr == laneIdxT'(i));
		assign lanes[i].seed = itemSeed;
		assign lanes[i].bucketId = itemBucketId;
		assign lanes[i].isWrite = writePhase;
		assign laneReady[i] = lanes[i].ready;
	end

	// Stalled item stays put for the busy lane
	aHeldItemStable : assert property (@(posedge Clock) disable iff (reset)
		itemValid && !curReady |=> itemValid && $stable(itemSeed)
			&& $stable(itemBucketId) && $stable(lanePtr));

endmodule

//--- oramGeometryPkg.sv
// ----------------------------------------------------------------------
// ORAM tree geometry and pad lane constants
// Shared sizes for the seed generator, pad lanes and collector
// ----------------------------------------------------------------------
package oramGeometryPkg;

	// ------------------------------------------------------------------
	// Tree shape
	// ------------------------------------------------------------------

	// Levels below the root, also the leaf label width
	localparam int OramLevels = 4;

	// Root plus one bucket per level
	localparam int PathBuckets = OramLevels + 1;

	// Heap index width, 31 buckets fit in 5 bits
	localparam int BucketIdWidth = 5;

	// Depth counter and per-pass transfer counter width
	localparam int LevelWidth = $clog2(PathBuckets);

	// ------------------------------------------------------------------
	// Seed and pad datapath
	// ------------------------------------------------------------------

	// Counter, seeds, key and pads all share this width
	localparam int SeedWidth = 64;

	// Parallel mixer lanes, filled round-robin
	localparam int LaneCount = 4;

	// Mixing rounds per pad
	localparam int PadRounds = 4;

	// Left rotate per round
	localparam int PadRotate = 7;

	// Round counter must reach PadRounds itself
	localparam int RoundWidth = $clog2(PadRounds + 1);

endpackage

//--- oramPadTop.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// ORAM bucket pad subsystem top
// Seed generator, parallel pad lanes and in-order collector
// ----------------------------------------------------------------------
module oramPadTop (
	input  logic                   Clock,
	input  logic                   reset,
	// Changed only while reset is high
	input  seedTypesPkg::seedT     key,
	output logic                   padValid,
	input  logic                   padReady,
	output seedTypesPkg::seedT     pad,
	output seedTypesPkg::bucketIdT padBucketId,
	output logic                   padIsWrite
);
	import oramGeometryPkg::*;

	// ------------------------------------------------------------------
	// Internal links
	// ------------------------------------------------------------------

	// Generator to lanes, seeds
	seedLaneIf toLane [LaneCount-1:0] ();

	// Lanes to collector, seed field holds the pad
	seedLaneIf fromLane [LaneCount-1:0] ();

	// ------------------------------------------------------------------
	// Blocks
	// ------------------------------------------------------------------
	gentrySeedGen seedGen (
		.Clock(Clock),
		.reset(reset),
		.lanes(toLane)
	);

	// Identical lanes, filled and drained in the same order
	for (genvar i = 0; i < LaneCount; i++) begin : gPadLane
		padLane lane (
			.Clock(Clock),
			.reset(reset),
			.key(key),
			.seedIn(toLane[i]),
			.padOut(fromLane[i])
		);
	end

	padCollector collector (
		.Clock(Clock),
		.reset(reset),
		.lanes(fromLane),
		.padValid(padValid),
		.padReady(padReady),
		.pad(pad),
		.padBucketId(padBucketId),
		.padIsWrite(padIsWrite)
	);

endmodule

//--- oramSeed.f
oramGeometryPkg.sv
seedTypesPkg.sv
seedLaneIf.sv
bucketIdGen.sv
gentrySeedGen.sv
padLane.sv
padCollector.sv
oramPadTop.sv
tbOramPad.sv

//--- padCollector.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Pad collector
// Drains the lanes round-robin so pads leave in generation order
// ----------------------------------------------------------------------
module padCollector (
	input  logic                   Clock,
	input  logic                   reset,
	seedLaneIf.sink                lanes [oramGeometryPkg::LaneCount-1:0],
	output logic                   padValid,
	input  logic                   padReady,
	output seedTypesPkg::seedT     pad,
	output seedTypesPkg::bucketIdT padBucketId,
	output logic                   padIsWrite
);
	import oramGeometryPkg::*;
	import seedTypesPkg::*;

	// Lane whose pad goes out next
	laneIdxT rdPtr;
	logic [LaneCount-1:0] laneValid;
	logic [LaneCount-1:0] laneWrite;
	seedT laneSeed [LaneCount];
	bucketIdT laneBucketId [LaneCount];

	// ------------------------------------------------------------------
	// Lane gather
	// ------------------------------------------------------------------
	for (genvar i = 0; i < LaneCount; i++) begin : gLane
		assign laneValid[i] = lanes[i].valid;
		assign laneSeed[i] = lanes[i].seed;
		assign laneBucketId[i] = lanes[i].bucketId;
		assign laneWrite[i] = lanes[i].isWrite;
		// Ready only toward the selected lane
		// Low padReady holds every lane full
		assign lanes[i].ready = padReady && (rdPtr == laneIdxT'(i));
	end

	// Selected lane straight onto the output
	assign padValid = laneValid[rdPtr];
	assign pad = laneSeed[rdPtr];
	assign padBucketId = laneBucketId[rdPtr];
	assign padIsWrite = laneWrite[rdPtr];

	// ------------------------------------------------------------------
	// Pointer
	// ------------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (reset)
			rdPtr <= '0;
		else if (padValid && padReady)
			rdPtr <= laneIdxT'(rdPtr + 1'b1);
	end

	// Stalled output holds, lane must keep its pad
	aStallStable : assert property (@(posedge Clock) disable iff (reset)
		padValid && !padReady |=> padValid && $stable(pad)
			&& $stable(padBucketId) && $stable(padIsWrite));

endmodule

//--- padLane.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Pad lane
// Keyed multi-round mixer, one seed in and one pad out per use
// ----------------------------------------------------------------------
module padLane (
	input logic               Clock,
	input logic               reset,
	input seedTypesPkg::seedT key,
	seedLaneIf.sink           seedIn,
	seedLaneIf.source         padOut
);
	import oramGeometryPkg::*;
	import seedTypesPkg::*;

	// Holding an item from accept until the pad is taken
	logic busy;
	logic outValid;
	logic [RoundWidth-1:0] roundCnt;
	logic acceptItem;
	logic releasePad;
	logic mixing;
	logic roundsDone;
	seedT mixState;
	bucketIdT latchedId;
	logic latchedWrite;

	// One round, key xor then rotate then add round number
	function automatic seedT mixRound(
		seedT inState,
		seedT roundKey,
		logic [RoundWidth-1:0] roundNum
	);
		seedT keyed;
		seedT rotated;
		keyed = inState ^ roundKey;
		rotated = (keyed << PadRotate) | (keyed >> (SeedWidth - PadRotate));
		return rotated + SeedWidth'(roundNum);
	endfunction

	assign acceptItem = seedIn.valid && seedIn.ready;
	assign releasePad = padOut.valid && padOut.ready;
	assign mixing = busy && !outValid;
	assign roundsDone = roundCnt == RoundWidth'(PadRounds);

	// Only an idle lane takes work
	assign seedIn.ready = !busy;

	// ------------------------------------------------------------------
	// Control
	// ------------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (reset) begin
			busy <= 1'b0;
			outValid <= 1'b0;
			roundCnt <= '0;
		end else if (acceptItem) begin
			busy <= 1'b1;
			roundCnt <= '0;
		end else if (mixing) begin
			// Extra cycle after the last round raises valid
			if (roundsDone)
				outValid <= 1'b1;
			else
				roundCnt <= roundCnt + 1'b1;
		end else if (releasePad) begin
			busy <= 1'b0;
			outValid <= 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// Datapath
	// ------------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (acceptItem) begin
			// Bucket index folded into the low bits
			mixState <= seedIn.seed ^ SeedWidth'(seedIn.bucketId);
			latchedId <= seedIn.bucketId;
			latchedWrite <= seedIn.isWrite;
		end else if (mixing && !roundsDone) begin
			mixState <= mixRound(mixState, key, RoundWidth'(roundCnt + 1'b1));
		end
	end

	assign padOut.valid = outValid;
	assign padOut.seed = mixState;
	assign padOut.bucketId = latchedId;
	assign padOut.isWrite = latchedWrite;

	// No second accept before the collector has taken the pad
	aNoAcceptWhileBusy : assert property (@(posedge Clock) disable iff (reset)
		acceptItem |=> !acceptItem until releasePad);

endmodule

//--- seedLaneIf.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Seed lane link, one item plus valid/ready handshake
// ----------------------------------------------------------------------
interface seedLaneIf;
	import seedTypesPkg::*;

	// Handshake
	logic valid;
	logic ready;

	// Payload, seed field also carries finished pads
	seedT seed;
	bucketIdT bucketId;
	logic isWrite;

	// Producer side
	modport source (
		output valid,
		output seed,
		output bucketId,
		output isWrite,
		input  ready
	);

	// Consumer side
	modport sink (
		input  valid,
		input  seed,
		input  bucketId,
		input  isWrite,
		output ready
	);

endinterface

//--- seedTypesPkg.sv
// ----------------------------------------------------------------------
// Seed, pad and bucket types plus the read/write phase encoding
// ----------------------------------------------------------------------
package seedTypesPkg;

	// Path counter, seed, key or pad
	typedef logic [oramGeometryPkg::SeedWidth-1:0] seedT;

	// Heap bucket index
	// Root is 0, children of n are 2n+1 and 2n+2
	typedef logic [oramGeometryPkg::BucketIdWidth-1:0] bucketIdT;

	// Leaf label, bit k picks the child below level k
	typedef logic [oramGeometryPkg::OramLevels-1:0] leafT;

	// Lane select for round-robin dispatch and drain
	typedef logic [$clog2(oramGeometryPkg::LaneCount)-1:0] laneIdxT;

	// Generator phases
	// Each start state is a single load cycle
	typedef enum logic [1:0] {
		StartRead,
		Read,
		StartWrite,
		Write
	} rwPhaseT;

endpackage

//--- tbOramPad.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Testbench for the ORAM bucket pad subsystem
// Table of keys and ready modes checked against a path reference model
// ----------------------------------------------------------------------
module tbOramPad;
	import oramGeometryPkg::*;
	import seedTypesPkg::*;

	// Output-side ready behavior per table row
	typedef enum logic [1:0] {
		ReadyHigh,
		ReadyRandom,
		ReadyMostlyLow
	} readyModeT;

	typedef struct packed {
		seedT key;
		readyModeT mode;
		logic [7:0] paths;
	} rowT;

	// ------------------------------------------------------------------
	// Stimulus table
	// ------------------------------------------------------------------
	localparam int RowCount = 4;
	// Rows 0 and 1 run past 16 paths so the leaf bits wrap
	localparam rowT StimTable [RowCount] = '{
		'{key: 64'h0123_4567_89ab_cdef, mode: ReadyHigh, paths: 8'd18},
		'{key: 64'h9e37_79b9_7f4a_7c15, mode: ReadyRandom, paths: 8'd20},
		'{key: 64'h0000_0000_0000_0000, mode: ReadyMostlyLow, paths: 8'd5},
		'{key: 64'hffff_ffff_ffff_ffff, mode: ReadyRandom, paths: 8'd3}
	};

	logic Clock;
	logic reset;
	seedT key;
	logic padValid;
	logic padReady;
	seedT pad;
	bucketIdT padBucketId;
	logic padIsWrite;

	logic [31:0] rngState;
	int cycleCount;
	int timeoutLimit;

	oramPadTop dut (
		.Clock(Clock),
		.reset(reset),
		.key(key),
		.padValid(padValid),
		.padReady(padReady),
		.pad(pad),
		.padBucketId(padBucketId),
		.padIsWrite(padIsWrite)
	);

	// 10 ns period
	always #5 Clock = ~Clock;

	// ------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------

	// xorshift32 step
	function automatic logic [31:0] nextRandom(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Heap index at a given depth
	// Bit k of the leaf picks the child below level k
	function automatic bucketIdT bucketAtLevel(input leafT leaf, input int level);
		int idx;
		idx = 0;
		for (int k = 0; k < level; k++)
			idx = 2 * idx + 1 + int'(leaf[k]);
		return bucketIdT'(idx);
	endfunction

	// Seed xor bucket index followed by PadRounds keyed rounds
	function automatic seedT referencePad(input seedT seed, input bucketIdT id, input seedT k);
		seedT s;
		s = seed ^ {{(SeedWidth - BucketIdWidth){1'b0}}, id};
		for (int r = 1; r <= PadRounds; r++) begin
			s = s ^ k;
			s = (s << PadRotate) | (s >> (SeedWidth - PadRotate));
			s = s + SeedWidth'(r);
		end
		return s;
	endfunction

	// ------------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------------
	task automatic compareSeed(input seedT actual, input seedT expected, input string what);
		if (actual !== expected) begin
			$display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
			$display("Errors found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic compareBucket(input bucketIdT actual, input bucketIdT expected,
		input string what);
		if (actual !== expected) begin
			$display("error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("Errors found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic compareFlag(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("error at %0t: %s is %b, expected %b", $time, what, actual, expected);
			$display("Errors found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// Key changes only while reset is held for 4 cycles
	task automatic resetDut(input seedT newKey);
		@(negedge Clock);
		reset = 1'b1;
		key = newKey;
		padReady = 1'b0;
		repeat (4) begin
			@(negedge Clock);
			compareFlag(padValid, 1'b0, "padValid in reset");
		end
		reset = 1'b0;
	endtask

	task automatic driveReady(input readyModeT mode);
		rngState = nextRandom(rngState);
		case (mode)
			ReadyHigh: padReady = 1'b1;
			ReadyRandom: padReady = rngState[0];
			default: padReady = rngState[2:0] == 3'd0;
		endcase
	endtask

	// ------------------------------------------------------------------
	// Timeout
	// ------------------------------------------------------------------
	always @(posedge Clock) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= timeoutLimit) begin
			$display("Timeout: pads still missing after %0d cycles", cycleCount);
			$display("Errors found");
			$fatal(1, "run did not finish");
		end
	end

	// ------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------
	initial begin
		seedT modelCounter;
		logic modelWrite;
		int modelLevel;
		int rowPads;
		int received;
		seedT expSeed;
		bucketIdT expId;
		logic held;
		seedT heldPad;
		bucketIdT heldId;
		logic heldWrite;
		Clock = 1'b0;
		reset = 1'b1;
		key = '0;
		padReady = 1'b0;
		rngState = 32'h66d8;
		cycleCount = 0;
		timeoutLimit = 100;
		for (int i = 0; i < RowCount; i++)
			timeoutLimit += int'(StimTable[i].paths) * 10 * (PadRounds + 2) * 8;
		for (int row = 0; row < RowCount; row++) begin
			resetDut(StimTable[row].key);
			// Model restarts with the counter-zero read pass at the root
			modelCounter = '0;
			modelWrite = 1'b0;
			modelLevel = 0;
			held = 1'b0;
			rowPads = int'(StimTable[row].paths) * 10;
			received = 0;
			while (received < rowPads) begin
				@(negedge Clock);
				driveReady(StimTable[row].mode);
				#1;
				// Stalled pad must not move or vanish
				if (held) begin
					compareFlag(padValid, 1'b1, "padValid while stalled");
					compareSeed(pad, heldPad, "pad while stalled");
					compareBucket(padBucketId, heldId, "padBucketId while stalled");
					compareFlag(padIsWrite, heldWrite, "padIsWrite while stalled");
				end
				if (padValid && padReady) begin
					expSeed = (modelCounter >> modelLevel) + SeedWidth'(modelWrite);
					expId = bucketAtLevel(modelCounter[OramLevels-1:0], modelLevel);
					compareFlag(padIsWrite, modelWrite,
						$sformatf("padIsWrite path %0d level %0d", modelCounter, modelLevel));
					compareBucket(padBucketId, expId,
						$sformatf("padBucketId path %0d level %0d", modelCounter, modelLevel));
					compareSeed(pad, referencePad(expSeed, expId, StimTable[row].key),
						$sformatf("pad path %0d level %0d", modelCounter, modelLevel));
					received++;
					// Root to leaf in each pass, read before write
					modelLevel++;
					if (modelLevel == PathBuckets) begin
						modelLevel = 0;
						if (modelWrite)
							modelCounter = modelCounter + SeedWidth'(1);
						modelWrite = !modelWrite;
					end
				end
				held = padValid && !padReady;
				heldPad = pad;
				heldId = padBucketId;
				heldWrite = padIsWrite;
			end
		end
		$display("No errors");
		$finish;
	end

endmodule
